// ==== Makefile ====
SRCS := build.f $(wildcard design/*.sv design/*.svh verif/*.sv)

.PHONY: all run clean

all: run

obj_dir/Vex_stage_tb: $(SRCS)
	verilator --binary --timing --assert --top-module ex_stage_tb -Mdir obj_dir -f build.f

run: obj_dir/Vex_stage_tb
	./obj_dir/Vex_stage_tb > sim.log 2>&1 || true
	cat sim.log
	grep -q -F "*** TEST PASSED ***" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== build.f ====
+incdir+design
design/ex_pkg.sv
design/ex_decode.sv
design/ex_alu.sv
design/ex_branch.sv
design/ex_lsu_req.sv
design/ex_mem_reg.sv
design/ex_stage.sv
verif/ex_stage_tb.sv

// ==== design/ex_alu.sv ====
`timescale 1ns/10ps
`include "ex_cfg.svh"

module ex_alu import ex_pkg::*; (
    input  alu_op_e alu_op_i,
    input  word_t   a_i,
    input  word_t   b_i,
    output word_t   result_o
);

    logic [4:0] shamt;
    logic       lt_s;
    logic       lt_u;

    assign shamt = b_i[4:0];           // same bits for slli and sll
    assign lt_s  = $signed(a_i) < $signed(b_i);
    assign lt_u  = a_i < b_i;

    always_comb begin
        case (alu_op_i)
            ALU_ADD:  result_o = a_i + b_i;
            ALU_SLT:  result_o = {{(`XLEN-1){1'b0}}, lt_s};
            ALU_SLTU: result_o = {{(`XLEN-1){1'b0}}, lt_u};
            ALU_XOR:  result_o = a_i ^ b_i;
            ALU_OR:   result_o = a_i | b_i;
            ALU_AND:  result_o = a_i & b_i;
            ALU_SLL:  result_o = a_i << shamt;
            default:  result_o = a_i >> shamt;  // srl
        endcase
    end

endmodule

// ==== design/ex_branch.sv ====
`timescale 1ns/10ps
`include "ex_cfg.svh"

module ex_branch import ex_pkg::*; (
    input  funct3_t funct3_i,
    input  logic    is_branch_i,
    input  logic    is_jump_i,
    input  word_t   rs1_i,
    input  word_t   rs2_i,
    input  word_t   base_i,
    input  word_t   ofs_i,
    output logic    taken_o,
    output word_t   target_o
);

    logic eq;
    logic lt_s;
    logic lt_u;
    logic cond;

    // one comparator set feeds all six conditions
    assign eq   = rs1_i == rs2_i;
    assign lt_s = $signed(rs1_i) < $signed(rs2_i);
    assign lt_u = rs1_i < rs2_i;

    always_comb begin
        case (funct3_i)
            `F3_BEQ:  cond = eq;
            `F3_BNE:  cond = !eq;
            `F3_BLT:  cond = lt_s;
            `F3_BGE:  cond = !lt_s;
            `F3_BLTU: cond = lt_u;
            `F3_BGEU: cond = !lt_u;
            default:  cond = 1'b0;
        endcase
    end

    assign taken_o  = is_jump_i || (is_branch_i && cond);
    assign target_o = base_i + ofs_i;

    always_comb begin
        assert (!taken_o || is_branch_i || is_jump_i)
            else $error("ex_branch: taken without branch or jump");
    end

endmodule

// ==== design/ex_cfg.svh ====
`ifndef EX_CFG_SVH
`define EX_CFG_SVH

// datapath widths
`define XLEN            32
`define INST_W          32
`define REG_ADDR_W      5
`define FUNCT3_W        3
`define BYTE_EN_W       4
`define CACHE_ADDR_W    21

// word index slice of the byte address
`define CACHE_ADDR_HI   22
`define CACHE_ADDR_LO   2

// rv32i major opcodes
`define OPC_OP_IMM      7'b0010011
`define OPC_OP          7'b0110011
`define OPC_BRANCH      7'b1100011
`define OPC_JAL         7'b1101111
`define OPC_JALR        7'b1100111
`define OPC_LUI         7'b0110111
`define OPC_AUIPC       7'b0010111
`define OPC_LOAD        7'b0000011
`define OPC_STORE       7'b0100011

// alu funct3, shared by imm and reg forms
`define F3_ADD          3'b000
`define F3_SLL          3'b001
`define F3_SLT          3'b010
`define F3_SLTU         3'b011
`define F3_XOR          3'b100
`define F3_SRL          3'b101
`define F3_OR           3'b110
`define F3_AND          3'b111

// branch funct3
`define F3_BEQ          3'b000
`define F3_BNE          3'b001
`define F3_BLT          3'b100
`define F3_BGE          3'b101
`define F3_BLTU         3'b110
`define F3_BGEU         3'b111

// store funct3
`define F3_SB           3'b000
`define F3_SH           3'b001
`define F3_SW           3'b010

`endif

// ==== design/ex_decode.sv ====
`timescale 1ns/10ps
`include "ex_cfg.svh"

module ex_decode import ex_pkg::*; (
    input  inst_t     inst_i,
    input  word_t     reg2_rdata_i,
    input  word_t     imm_i,
    output op_class_e op_class_o,
    output alu_op_e   alu_op_o,
    output word_t     alu_b_o,
    output reg_addr_t rd_o
);

    logic [6:0] opcode;
    funct3_t    funct3;
    logic [6:0] funct7;

    assign opcode = inst_i[6:0];
    assign funct3 = inst_i[14:12];
    assign funct7 = inst_i[31:25];
    assign rd_o   = inst_i[11:7];

    // funct3 maps the same way for both alu forms
    always_comb begin
        case (funct3)
            `F3_ADD:  alu_op_o = ALU_ADD;
            `F3_SLL:  alu_op_o = ALU_SLL;
            `F3_SLT:  alu_op_o = ALU_SLT;
            `F3_SLTU: alu_op_o = ALU_SLTU;
            `F3_XOR:  alu_op_o = ALU_XOR;
            `F3_SRL:  alu_op_o = ALU_SRL;
            `F3_OR:   alu_op_o = ALU_OR;
            default:  alu_op_o = ALU_AND;
        endcase
    end

    always_comb begin
        op_class_o = CLS_NONE;
        alu_b_o    = imm_i;            // immediate unless register form
        case (opcode)
            `OPC_OP_IMM: op_class_o = CLS_ALU;
            `OPC_OP: begin
                alu_b_o = reg2_rdata_i;
                if (funct7 == 7'd0) begin
                    op_class_o = CLS_ALU;  // sub/sra style encodings stay none
                end
            end
            `OPC_BRANCH: begin
                if (funct3 != 3'b010 && funct3 != 3'b011) begin
                    op_class_o = CLS_BRANCH;
                end
            end
            `OPC_JAL,
            `OPC_JALR:   op_class_o = CLS_JUMP;
            `OPC_LUI:    op_class_o = CLS_LUI;
            `OPC_AUIPC:  op_class_o = CLS_AUIPC;
            `OPC_LOAD:   op_class_o = CLS_LOAD;
            `OPC_STORE: begin
                if (funct3 == `F3_SB || funct3 == `F3_SH || funct3 == `F3_SW) begin
                    op_class_o = CLS_STORE;
                end
            end
            default:     op_class_o = CLS_NONE; // fence and unknown opcodes
        endcase
    end

endmodule

// ==== design/ex_lsu_req.sv ====
`timescale 1ns/10ps
`include "ex_cfg.svh"

module ex_lsu_req import ex_pkg::*; (
    input  inst_t       inst_i,
    input  word_t       rs1_i,
    input  word_t       rs2_i,
    input  word_t       imm_i,
    output cache_addr_t addr_o,
    output byte_en_t    byte_en_o,
    output word_t       wdata_o,
    output logic [1:0]  offset_o
);

    funct3_t funct3;
    word_t   eff_addr;

    assign funct3   = inst_i[14:12];
    assign eff_addr = rs1_i + imm_i;
    assign addr_o   = eff_addr[`CACHE_ADDR_HI:`CACHE_ADDR_LO];
    assign offset_o = eff_addr[1:0];   // byte within the word

    // store lane steering
    always_comb begin
        case (funct3)
            `F3_SB: begin
                byte_en_o = byte_en_t'(1) << offset_o;
                wdata_o   = word_t'(rs2_i[7:0]) << {offset_o, 3'b000};
            end
            `F3_SH: begin
                if (offset_o[1]) begin
                    byte_en_o = 4'b1100;
                    wdata_o   = {rs2_i[15:0], 16'h0000};
                end else begin
                    byte_en_o = 4'b0011;
                    wdata_o   = {16'h0000, rs2_i[15:0]};
                end
            end
            `F3_SW: begin
                byte_en_o = 4'b1111;
                wdata_o   = rs2_i;
            end
            default: begin
                byte_en_o = '0;
                wdata_o   = '0;
            end
        endcase
    end

    always_comb begin
        if (funct3 == `F3_SB) begin
            assert ($onehot(byte_en_o))
                else $error("ex_lsu_req: sb mask %b not one-hot", byte_en_o);
        end
    end

endmodule

// ==== design/ex_mem_reg.sv ====
`timescale 1ns/10ps
`include "ex_cfg.svh"

module ex_mem_reg import ex_pkg::*; (
    input  logic        clk,
    input  logic        rst_n_i,
    input  op_class_e   op_class_i,
    input  reg_addr_t   rd_i,
    input  funct3_t     funct3_i,
    input  word_t       inst_addr_i,
    input  word_t       imm_i,
    input  word_t       alu_result_i,
    input  logic        taken_i,
    input  word_t       target_i,
    input  cache_addr_t addr_i,
    input  byte_en_t    byte_en_i,
    input  word_t       wdata_i,
    input  logic [1:0]  offset_i,
    output logic        reg_we_o,
    output reg_addr_t   reg_waddr_o,
    output word_t       reg_wdata_o,
    output logic        jump_flag_o,
    output word_t       jump_addr_o,
    output logic        hold_flag_o,
    output cache_addr_t mem_addr_o,
    output byte_en_t    mem_byte_en_o,
    output word_t       mem_wdata_o,
    output logic        mem_read_o,
    output logic        mem_write_o,
    output reg_addr_t   wait_rd_o,
    output logic [1:0]  wait_offset_o,
    output funct3_t     wait_funct3_o
);

    logic        reg_we_d;
    word_t       reg_wdata_d;
    logic        jump_flag_d;
    word_t       jump_addr_d;
    logic        mem_read_d;
    logic        mem_write_d;
    cache_addr_t mem_addr_d;
    byte_en_t    mem_byte_en_d;
    word_t       mem_wdata_d;
    logic        load_tag;

    always_comb begin
        reg_we_d      = 1'b0;
        reg_wdata_d   = '0;
        jump_flag_d   = 1'b0;
        jump_addr_d   = '0;
        mem_read_d    = 1'b0;
        mem_write_d   = 1'b0;
        mem_addr_d    = '0;
        mem_byte_en_d = '0;
        mem_wdata_d   = '0;
        case (op_class_i)
            CLS_ALU: begin
                reg_we_d    = 1'b1;
                reg_wdata_d = alu_result_i;
            end
            CLS_BRANCH: begin
                jump_flag_d = taken_i;
                jump_addr_d = target_i;
            end
            CLS_JUMP: begin
                reg_we_d    = 1'b1;
                reg_wdata_d = inst_addr_i + `XLEN'(4);  // link
                jump_flag_d = taken_i;
                jump_addr_d = target_i;
            end
            CLS_LUI: begin
                reg_we_d    = 1'b1;
                reg_wdata_d = imm_i;
            end
            CLS_AUIPC: begin
                reg_we_d    = 1'b1;
                reg_wdata_d = inst_addr_i + imm_i;
            end
            CLS_LOAD: begin
                mem_read_d = 1'b1;
                mem_addr_d = addr_i;
            end
            CLS_STORE: begin
                mem_write_d   = 1'b1;
                mem_addr_d    = addr_i;
                mem_byte_en_d = byte_en_i;
                mem_wdata_d   = wdata_i;
            end
            default: begin
                reg_we_d = 1'b0;
            end
        endcase
    end

    assign load_tag = op_class_i == CLS_LOAD;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            reg_we_o      <= 1'b0;
            reg_waddr_o   <= '0;
            reg_wdata_o   <= '0;
            jump_flag_o   <= 1'b0;
            jump_addr_o   <= '0;
            hold_flag_o   <= 1'b0;
            mem_addr_o    <= '0;
            mem_byte_en_o <= '0;
            mem_wdata_o   <= '0;
            mem_read_o    <= 1'b0;
            mem_write_o   <= 1'b0;
            wait_rd_o     <= '0;
            wait_offset_o <= '0;
            wait_funct3_o <= '0;
        end else begin
            reg_we_o      <= reg_we_d;
            reg_waddr_o   <= reg_we_d ? rd_i : '0;
            reg_wdata_o   <= reg_wdata_d;
            jump_flag_o   <= jump_flag_d;
            jump_addr_o   <= jump_addr_d;
            hold_flag_o   <= load_tag;     // stall until the load returns
            mem_addr_o    <= mem_addr_d;
            mem_byte_en_o <= mem_byte_en_d;
            mem_wdata_o   <= mem_wdata_d;
            mem_read_o    <= mem_read_d;
            mem_write_o   <= mem_write_d;
            wait_rd_o     <= load_tag ? rd_i : '0;
            wait_offset_o <= load_tag ? offset_i : 2'b00;
            wait_funct3_o <= load_tag ? funct3_i : '0;
        end
    end

    a_rd_wr_excl: assert property (@(posedge clk) disable iff (!rst_n_i)
        !(mem_read_o && mem_write_o))
        else $error("ex_mem_reg: read and write strobes both high");

endmodule

// ==== design/ex_pkg.sv ====
`include "ex_cfg.svh"

package ex_pkg;

    typedef logic [`XLEN-1:0]         word_t;
    typedef logic [`REG_ADDR_W-1:0]   reg_addr_t;
    typedef logic [`INST_W-1:0]       inst_t;
    typedef logic [`FUNCT3_W-1:0]     funct3_t;
    typedef logic [`BYTE_EN_W-1:0]    byte_en_t;
    typedef logic [`CACHE_ADDR_W-1:0] cache_addr_t;

    // instruction class seen by the output register
    typedef enum logic [2:0] {
        CLS_NONE,
        CLS_ALU,
        CLS_BRANCH,
        CLS_JUMP,
        CLS_LUI,
        CLS_AUIPC,
        CLS_LOAD,
        CLS_STORE
    } op_class_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_OR,
        ALU_AND,
        ALU_SLL,
        ALU_SRL
    } alu_op_e;

endpackage

// ==== design/ex_stage.sv ====
`timescale 1ns/10ps
`include "ex_cfg.svh"

module ex_stage import ex_pkg::*; (
    input  logic        clk,
    input  logic        rst_n_i,
    // from id
    input  inst_t       inst_i,
    input  word_t       inst_addr_i,
    input  word_t       reg1_rdata_i,
    input  word_t       reg2_rdata_i,
    input  word_t       imm_i,
    input  word_t       jump_base_i,
    input  word_t       jump_ofs_i,
    // write-back
    output logic        reg_we_o,
    output reg_addr_t   reg_waddr_o,
    output word_t       reg_wdata_o,
    // control
    output logic        jump_flag_o,
    output word_t       jump_addr_o,
    output logic        hold_flag_o,
    // data cache
    output cache_addr_t mem_addr_o,
    output byte_en_t    mem_byte_en_o,
    output word_t       mem_wdata_o,
    output logic        mem_read_o,
    output logic        mem_write_o,
    // load write-back tag
    output reg_addr_t   wait_rd_o,
    output logic [1:0]  wait_offset_o,
    output funct3_t     wait_funct3_o
);

    op_class_e   op_class;
    alu_op_e     alu_op;
    word_t       alu_b;
    reg_addr_t   rd;
    funct3_t     funct3;
    word_t       alu_result;
    logic        is_branch;
    logic        is_jump;
    logic        taken;
    word_t       target;
    cache_addr_t lsu_addr;
    byte_en_t    lsu_byte_en;
    word_t       lsu_wdata;
    logic [1:0]  lsu_offset;

    assign funct3    = inst_i[14:12];
    assign is_branch = op_class == CLS_BRANCH;
    assign is_jump   = op_class == CLS_JUMP;

    ex_decode u_decode (
        .inst_i       (inst_i),
        .reg2_rdata_i (reg2_rdata_i),
        .imm_i        (imm_i),
        .op_class_o   (op_class),
        .alu_op_o     (alu_op),
        .alu_b_o      (alu_b),
        .rd_o         (rd)
    );

    ex_alu u_alu (
        .alu_op_i (alu_op),
        .a_i      (reg1_rdata_i),
        .b_i      (alu_b),
        .result_o (alu_result)
    );

    ex_branch u_branch (
        .funct3_i    (funct3),
        .is_branch_i (is_branch),
        .is_jump_i   (is_jump),
        .rs1_i       (reg1_rdata_i),
        .rs2_i       (reg2_rdata_i),
        .base_i      (jump_base_i),
        .ofs_i       (jump_ofs_i),
        .taken_o     (taken),
        .target_o    (target)
    );

    ex_lsu_req u_lsu_req (
        .inst_i    (inst_i),
        .rs1_i     (reg1_rdata_i),
        .rs2_i     (reg2_rdata_i),
        .imm_i     (imm_i),
        .addr_o    (lsu_addr),
        .byte_en_o (lsu_byte_en),
        .wdata_o   (lsu_wdata),
        .offset_o  (lsu_offset)
    );

    ex_mem_reg u_mem_reg (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .op_class_i    (op_class),
        .rd_i          (rd),
        .funct3_i      (funct3),
        .inst_addr_i   (inst_addr_i),
        .imm_i         (imm_i),
        .alu_result_i  (alu_result),
        .taken_i       (taken),
        .target_i      (target),
        .addr_i        (lsu_addr),
        .byte_en_i     (lsu_byte_en),
        .wdata_i       (lsu_wdata),
        .offset_i      (lsu_offset),
        .reg_we_o      (reg_we_o),
        .reg_waddr_o   (reg_waddr_o),
        .reg_wdata_o   (reg_wdata_o),
        .jump_flag_o   (jump_flag_o),
        .jump_addr_o   (jump_addr_o),
        .hold_flag_o   (hold_flag_o),
        .mem_addr_o    (mem_addr_o),
        .mem_byte_en_o (mem_byte_en_o),
        .mem_wdata_o   (mem_wdata_o),
        .mem_read_o    (mem_read_o),
        .mem_write_o   (mem_write_o),
        .wait_rd_o     (wait_rd_o),
        .wait_offset_o (wait_offset_o),
        .wait_funct3_o (wait_funct3_o)
    );

endmodule

// ==== verif/ex_stage_tb.sv ====
`timescale 1ns/10ps
`include "ex_cfg.svh"

module ex_stage_tb import ex_pkg::*; ();

    localparam int N_INST     = 400;
    localparam int RST_CYCLES = 2;
    localparam int TIMEOUT_NS = (RST_CYCLES + N_INST + 4) * 20 + 400;

    // checked output fields
    localparam int F_WE     = 0;
    localparam int F_WADDR  = 1;
    localparam int F_WDATA  = 2;
    localparam int F_JFLAG  = 3;
    localparam int F_JADDR  = 4;
    localparam int F_HOLD   = 5;
    localparam int F_MADDR  = 6;
    localparam int F_BEN    = 7;
    localparam int F_MWDATA = 8;
    localparam int F_MREAD  = 9;
    localparam int F_MWRITE = 10;
    localparam int F_WRD    = 11;
    localparam int F_WOFS   = 12;
    localparam int F_WF3    = 13;
    localparam int N_FIELDS = 14;

    // instruction kinds, plus one for cycles under reset
    localparam int K_NONE   = 0;
    localparam int K_ALU    = 1;
    localparam int K_BRANCH = 2;
    localparam int K_JUMP   = 3;
    localparam int K_LUI    = 4;
    localparam int K_AUIPC  = 5;
    localparam int K_LOAD   = 6;
    localparam int K_STORE  = 7;
    localparam int K_RESET  = 8;
    localparam int K_COUNT  = 9;

    logic        clk;
    logic        rst_n;
    inst_t       inst;
    word_t       inst_addr;
    word_t       reg1;
    word_t       reg2;
    word_t       imm;
    word_t       jbase;
    word_t       jofs;

    logic        reg_we;
    reg_addr_t   reg_waddr;
    word_t       reg_wdata;
    logic        jump_flag;
    word_t       jump_addr;
    logic        hold_flag;
    cache_addr_t mem_addr;
    byte_en_t    mem_byte_en;
    word_t       mem_wdata;
    logic        mem_read;
    logic        mem_write;
    reg_addr_t   wait_rd;
    logic [1:0]  wait_offset;
    funct3_t     wait_funct3;

    word_t       lcg_state;
    word_t       exp_v [N_FIELDS];
    word_t       obs_v [N_FIELDS];
    logic        chk_valid;
    int          chk_kind;
    int          n_checked;
    int          mismatches;
    int          other_errs;
    int          kind_seen [K_COUNT];
    int          branch_taken [2];

    ex_stage dut_i (
        .clk           (clk),
        .rst_n_i       (rst_n),
        .inst_i        (inst),
        .inst_addr_i   (inst_addr),
        .reg1_rdata_i  (reg1),
        .reg2_rdata_i  (reg2),
        .imm_i         (imm),
        .jump_base_i   (jbase),
        .jump_ofs_i    (jofs),
        .reg_we_o      (reg_we),
        .reg_waddr_o   (reg_waddr),
        .reg_wdata_o   (reg_wdata),
        .jump_flag_o   (jump_flag),
        .jump_addr_o   (jump_addr),
        .hold_flag_o   (hold_flag),
        .mem_addr_o    (mem_addr),
        .mem_byte_en_o (mem_byte_en),
        .mem_wdata_o   (mem_wdata),
        .mem_read_o    (mem_read),
        .mem_write_o   (mem_write),
        .wait_rd_o     (wait_rd),
        .wait_offset_o (wait_offset),
        .wait_funct3_o (wait_funct3)
    );

    always #10 clk = ~clk;

    function automatic word_t lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return {lcg_state[15:0], lcg_state[31:16]};  // weak low bits moved up
    endfunction

    function automatic string kind_name(int k);
        case (k)
            K_NONE:   return "none";
            K_ALU:    return "alu";
            K_BRANCH: return "branch";
            K_JUMP:   return "jump";
            K_LUI:    return "lui";
            K_AUIPC:  return "auipc";
            K_LOAD:   return "load";
            K_STORE:  return "store";
            default:  return "reset";
        endcase
    endfunction

    function automatic string field_name(int f);
        case (f)
            F_WE:     return "reg_we_o";
            F_WADDR:  return "reg_waddr_o";
            F_WDATA:  return "reg_wdata_o";
            F_JFLAG:  return "jump_flag_o";
            F_JADDR:  return "jump_addr_o";
            F_HOLD:   return "hold_flag_o";
            F_MADDR:  return "mem_addr_o";
            F_BEN:    return "mem_byte_en_o";
            F_MWDATA: return "mem_wdata_o";
            F_MREAD:  return "mem_read_o";
            F_MWRITE: return "mem_write_o";
            F_WRD:    return "wait_rd_o";
            F_WOFS:   return "wait_offset_o";
            default:  return "wait_funct3_o";
        endcase
    endfunction

    function automatic int kind_of(inst_t in);
        funct3_t f3;
        f3 = in[14:12];
        case (in[6:0])
            `OPC_OP_IMM: return K_ALU;
            `OPC_OP:     return (in[31:25] == 7'd0) ? K_ALU : K_NONE;
            `OPC_BRANCH: return (f3 == 3'b010 || f3 == 3'b011) ? K_NONE : K_BRANCH;
            `OPC_JAL,
            `OPC_JALR:   return K_JUMP;
            `OPC_LUI:    return K_LUI;
            `OPC_AUIPC:  return K_AUIPC;
            `OPC_LOAD:   return K_LOAD;
            `OPC_STORE:  return (f3 <= `F3_SW) ? K_STORE : K_NONE;
            default:     return K_NONE;
        endcase
    endfunction

    function automatic word_t alu_rule(funct3_t f3, word_t a, word_t b);
        case (f3)
            `F3_ADD:  return a + b;
            `F3_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            `F3_SLTU: return (a < b) ? 32'd1 : 32'd0;
            `F3_XOR:  return a ^ b;
            `F3_OR:   return a | b;
            `F3_AND:  return a & b;
            `F3_SLL:  return a << b[4:0];
            default:  return a >> b[4:0];
        endcase
    endfunction

    function automatic logic branch_rule(funct3_t f3, word_t a, word_t b);
        case (f3)
            `F3_BEQ:  return a == b;
            `F3_BNE:  return a != b;
            `F3_BLT:  return $signed(a) < $signed(b);
            `F3_BGE:  return $signed(a) >= $signed(b);
            `F3_BLTU: return a < b;
            default:  return a >= b;
        endcase
    endfunction

    function automatic byte_en_t store_mask(funct3_t f3, logic [1:0] ofs);
        case (f3)
            `F3_SB:  return byte_en_t'(4'b0001 << ofs);
            `F3_SH:  return ofs[1] ? 4'b1100 : 4'b0011;
            default: return 4'b1111;
        endcase
    endfunction

    // data replicated over all lanes, then cut down by the mask
    function automatic word_t store_data(funct3_t f3, byte_en_t mask, word_t d);
        word_t rep;
        word_t keep;
        case (f3)
            `F3_SB:  rep = {4{d[7:0]}};
            `F3_SH:  rep = {2{d[15:0]}};
            default: rep = d;
        endcase
        for (int i = 0; i < 4; i++) begin
            keep[8*i +: 8] = {8{mask[i]}};
        end
        return rep & keep;
    endfunction

    task automatic predict();
        funct3_t   f3;
        reg_addr_t rd;
        word_t     eff;
        word_t     b;
        byte_en_t  mask;
        f3  = inst[14:12];
        rd  = inst[11:7];
        eff = reg1 + imm;
        b   = (inst[6:0] == `OPC_OP) ? reg2 : imm;
        for (int i = 0; i < N_FIELDS; i++) begin
            exp_v[i] = '0;
        end
        chk_kind = kind_of(inst);
        case (chk_kind)
            K_ALU: begin
                exp_v[F_WE]    = 32'd1;
                exp_v[F_WADDR] = 32'(rd);
                exp_v[F_WDATA] = alu_rule(f3, reg1, b);
            end
            K_BRANCH: begin
                exp_v[F_JFLAG] = 32'(branch_rule(f3, reg1, reg2));
                exp_v[F_JADDR] = jbase + jofs;
            end
            K_JUMP: begin
                exp_v[F_WE]    = 32'd1;
                exp_v[F_WADDR] = 32'(rd);
                exp_v[F_WDATA] = inst_addr + 32'd4;   // link
                exp_v[F_JFLAG] = 32'd1;
                exp_v[F_JADDR] = jbase + jofs;
            end
            K_LUI, K_AUIPC: begin
                exp_v[F_WE]    = 32'd1;
                exp_v[F_WADDR] = 32'(rd);
                exp_v[F_WDATA] = (chk_kind == K_LUI) ? imm : inst_addr + imm;
            end
            K_LOAD: begin
                exp_v[F_MREAD] = 32'd1;
                exp_v[F_HOLD]  = 32'd1;
                exp_v[F_MADDR] = 32'(eff[`CACHE_ADDR_HI:`CACHE_ADDR_LO]);
                exp_v[F_WRD]   = 32'(rd);
                exp_v[F_WOFS]  = 32'(eff[1:0]);
                exp_v[F_WF3]   = 32'(f3);
            end
            K_STORE: begin
                mask            = store_mask(f3, eff[1:0]);
                exp_v[F_MWRITE] = 32'd1;
                exp_v[F_MADDR]  = 32'(eff[`CACHE_ADDR_HI:`CACHE_ADDR_LO]);
                exp_v[F_BEN]    = 32'(mask);
                exp_v[F_MWDATA] = store_data(f3, mask, reg2);
            end
            default: begin
                exp_v[F_WE] = 32'd0;   // nothing may fire
            end
        endcase
    endtask

    // outputs now hold the result of the inputs seen at the last rising edge
    task automatic capture_for_check();
        if (rst_n) begin
            predict();
            if (chk_kind == K_BRANCH) begin
                branch_taken[exp_v[F_JFLAG][0]]++;
            end
        end else begin
            for (int i = 0; i < N_FIELDS; i++) begin
                exp_v[i] = '0;
            end
            chk_kind = K_RESET;
        end
        kind_seen[chk_kind]++;
        obs_v[F_WE]     = 32'(reg_we);
        obs_v[F_WADDR]  = 32'(reg_waddr);
        obs_v[F_WDATA]  = reg_wdata;
        obs_v[F_JFLAG]  = 32'(jump_flag);
        obs_v[F_JADDR]  = jump_addr;
        obs_v[F_HOLD]   = 32'(hold_flag);
        obs_v[F_MADDR]  = 32'(mem_addr);
        obs_v[F_BEN]    = 32'(mem_byte_en);
        obs_v[F_MWDATA] = mem_wdata;
        obs_v[F_MREAD]  = 32'(mem_read);
        obs_v[F_MWRITE] = 32'(mem_write);
        obs_v[F_WRD]    = 32'(wait_rd);
        obs_v[F_WOFS]   = 32'(wait_offset);
        obs_v[F_WF3]    = 32'(wait_funct3);
        chk_valid = 1'b1;
        n_checked++;
    endtask

    task automatic drive_random();
        word_t      r;
        word_t      fields;
        word_t      val;
        logic [6:0] opc;
        logic [6:0] f7;
        funct3_t    f3;
        int         pick;
        r    = lcg_next();
        pick = int'(r % 32'd11);
        case (pick)
            0:       opc = `OPC_OP_IMM;
            1, 2:    opc = `OPC_OP;
            3:       opc = `OPC_BRANCH;
            4:       opc = `OPC_JAL;
            5:       opc = `OPC_JALR;
            6:       opc = `OPC_LUI;
            7:       opc = `OPC_AUIPC;
            8:       opc = `OPC_LOAD;
            9:       opc = `OPC_STORE;
            default: opc = r[20] ? 7'b0001111 : 7'b1110011;  // fence or system
        endcase
        fields = lcg_next();
        f3     = fields[14:12];
        f7     = fields[31] ? 7'd0 : fields[31:25];
        if (opc == `OPC_STORE) begin
            f3 = {1'b0, fields[13:12]};   // sb, sh, sw and one illegal code
        end
        inst = {f7, fields[24:15], f3, fields[11:7], opc};
        reg1 = lcg_next();
        reg2 = lcg_next();
        val  = lcg_next();
        if (val[1:0] == 2'b00) begin
            reg2 = reg1;                  // equal operands for beq, bge
        end
        if (opc == `OPC_LUI || opc == `OPC_AUIPC) begin
            imm = {val[31:12], 12'h000};
        end else begin
            imm = {{20{val[31]}}, val[31:20]};
        end
        val       = lcg_next();
        inst_addr = {val[31:2], 2'b00};
        jbase     = lcg_next();
        val       = lcg_next();
        jofs      = {{19{val[12]}}, val[12:1], 1'b0};
    endtask

    task automatic note_mismatch(int f);
        mismatches++;
        $display("mismatch %s #%0d %s: expected 0x%08h actual 0x%08h",
                 kind_name(chk_kind), n_checked, field_name(f), exp_v[f], obs_v[f]);
    endtask

    // all operands are written at the falling edge, so stable here
    for (genvar g = 0; g < N_FIELDS; g++) begin : g_check
        a_field: assert property (@(posedge clk) !chk_valid || obs_v[g] == exp_v[g])
            else note_mismatch(g);
    end

    initial begin
        clk        = 1'b0;
        rst_n      = 1'b0;
        inst       = '0;
        inst_addr  = '0;
        reg1       = '0;
        reg2       = '0;
        imm        = '0;
        jbase      = '0;
        jofs       = '0;
        lcg_state  = 32'd53823;
        chk_valid  = 1'b0;
        chk_kind   = K_RESET;
        n_checked  = 0;
        mismatches = 0;
        other_errs = 0;
        foreach (kind_seen[k]) kind_seen[k] = 0;
        foreach (branch_taken[t]) branch_taken[t] = 0;
        foreach (exp_v[i]) exp_v[i] = '0;
        foreach (obs_v[i]) obs_v[i] = '0;

        // strobing instructions while reset is held
        for (int c = 0; c < RST_CYCLES; c++) begin
            drive_random();
            inst[6:0] = (c == 0) ? `OPC_JAL : `OPC_LOAD;
            @(negedge clk);
            capture_for_check();
        end
        rst_n = 1'b1;
        inst  = '0;                 // idle instruction first
        @(negedge clk);
        capture_for_check();

        for (int n = 0; n < N_INST; n++) begin
            drive_random();
            @(negedge clk);
            capture_for_check();
        end
        @(posedge clk);
        @(negedge clk);

        for (int k = 0; k < K_COUNT; k++) begin
            if (kind_seen[k] == 0) begin
                other_errs++;
                $display("no %s case was reached by the stimulus", kind_name(k));
            end
        end
        if (branch_taken[0] == 0 || branch_taken[1] == 0) begin
            other_errs++;
            $display("branches were not seen both taken and not taken");
        end

        $display("errors: %0d mismatch, %0d other, over %0d checked cycles",
                 mismatches, other_errs, n_checked);
        if (mismatches == 0 && other_errs == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("timeout: the run did not end within %0d ns", TIMEOUT_NS);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule
